/* bench/core_control_tb.sv */
/*
 * Testbench for the core control block.
 * Drives random control register accesses, faults and stalls from an LFSR
 * and checks every cycle against a cycle model of the registers and selector.
 */

`include "core_defines.svh"

module core_control_tb
	import control_pkg::*;
();
	localparam int RW_STEPS = 40;
	localparam int RO_STEPS = 12;
	localparam int FAULT_STEPS = 30;
	localparam int SCHED_STEPS = 60;
	// Reset, per-test step counts and the final drain
	localparam int TOTAL_CYCLES = 16 + 11 + RW_STEPS + (11 + RO_STEPS) + (FAULT_STEPS + 4)
		+ 8 + SCHED_STEPS + 4;

	typedef struct packed
	{
		logic                             rd;
		logic                             wr;
		logic [`STRAND_INDEX_WIDTH - 1:0] strand;
		logic [4:0]                       index;
		logic [`CR_WORD_WIDTH - 1:0]      value;
		logic                             fault;
		logic [`CR_WORD_WIDTH - 1:0]      pc;
		logic [`STRAND_INDEX_WIDTH - 1:0] fs;
		logic                             stall;
	} drive_t;

	typedef struct
	{
		logic [31:0] value;
		logic [4:0]  index;
		logic [1:0]  strand;
		int          stage;
	} read_entry_t;

	logic clk = 1'b0;
	logic reset;
	logic [1:0] ma_strand;
	logic [4:0] ma_index;
	logic ma_read_en;
	logic ma_write_en;
	logic [31:0] ma_write_value;
	logic wb_latch_fault;
	logic [31:0] wb_fault_pc;
	logic [1:0] wb_fault_strand;
	logic issue_stall;
	logic wb_read_valid;
	logic [31:0] wb_read_value;
	logic issue_valid;
	logic [1:0] issue_strand;
	logic [3:0] strand_enable;
	logic [31:0] exception_handler_address;

	// Next cycle's inputs, last driven inputs, and what sits on the bus
	drive_t nx = '0;
	drive_t pd = '0;
	drive_t s_acc = '0;
	// Model state starting from its reset values
	logic [3:0] m_mask = 4'b0001;
	logic [31:0] m_handler = '0;
	logic [31:0] m_fault_pc [4] = '{default: '0};
	logic m_issue_valid = 1'b0;
	// First search then lands on strand 0
	int m_last = `STRANDS_PER_CORE - 1;
	read_entry_t reads[$];
	logic [31:0] lfsr_state = 32'hfefa52d8;
	int cycle = 0;
	int value_errors = 0;
	int other_errors = 0;
	string test_name = "reset state";

	core_control_top #(.core_id(5)) u_dut (.*);

	always #10 clk = ~clk;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] model_read(input logic [1:0] strand, input logic [4:0] index);
		case (index)
			cr_strand_id:         return (32'd5 << 2) | 32'(strand);
			cr_exception_handler: return m_handler;
			cr_fault_address:     return m_fault_pc[strand];
			cr_strand_enable:     return 32'(m_mask);
			default:              return '0;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			value_errors++;
			$display("error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("%s (%s, cycle %0d)", msg, test_name, cycle);
	endtask

	// Model of one clock edge, fed with the inputs driven one cycle earlier
	task automatic apply_edge();
		read_entry_t entry;
		int cand;
		logic found;
		// Selector sees the mask from before this edge
		if (!pd.stall)
		begin
			found = 1'b0;
			cand = m_last;
			for (int i = 0; i < `STRANDS_PER_CORE; i++)
			begin
				cand = (cand + 1) % `STRANDS_PER_CORE;
				if (m_mask[cand])
				begin
					found = 1'b1;
					break;
				end
			end
			m_issue_valid = found;
			if (found)
				m_last = cand;
		end
		if (s_acc.wr)
		begin
			case (s_acc.index)
				cr_exception_handler: m_handler = s_acc.value;
				cr_strand_enable:     m_mask = s_acc.value[3:0];
				cr_halt_strand:       m_mask[s_acc.strand] = 1'b0;
				cr_halt:              m_mask = '0;
				default:              ;
			endcase
		end
		if (pd.fault)
			m_fault_pc[pd.fs] = pd.pc;
		// Read data reflects everything updated at this edge
		s_acc = pd;
		if (pd.rd)
		begin
			entry.value = model_read(pd.strand, pd.index);
			entry.index = pd.index;
			entry.strand = pd.strand;
			entry.stage = cycle;
			reads.push_back(entry);
		end
	endtask

	task automatic check_outputs();
		read_entry_t entry;
		cr_word_t word;
		check_value({test_name, " strand_enable"}, 32'(m_mask), 32'(strand_enable));
		check_value({test_name, " handler"}, m_handler, exception_handler_address);
		check_value({test_name, " issue_valid"}, 32'(m_issue_valid), 32'(issue_valid));
		// Last strand is kept even while nothing is enabled
		check_value({test_name, " issue_strand"}, 32'(m_last), 32'(issue_strand));
		if (wb_read_valid)
		begin
			assert (reads.size() != 0)
			else
				report_failure("read result arrived with no read outstanding");
			if (reads.size() != 0)
			begin
				entry = reads.pop_front();
				assert (entry.stage == cycle - 1)
				else
					report_failure("read result arrived in the wrong cycle");
				check_value({test_name, " read"}, entry.value, wb_read_value);
				// Strand ID decoded through the layout view
				word.raw = wb_read_value;
				if (entry.index == cr_strand_id)
				begin
					check_value("strand_id core", 32'd5, 32'(word.id.core));
					check_value("strand_id strand", 32'(entry.strand), 32'(word.id.strand));
				end
			end
		end
		else
		begin
			assert (reads.size() == 0 || reads[0].stage >= cycle)
			else
			begin
				report_failure("read was never answered");
				void'(reads.pop_front());
			end
		end
	endtask

	task automatic step();
		@(posedge clk);
		cycle++;
		apply_edge();
		pd = nx;
		ma_read_en <= nx.rd;
		ma_write_en <= nx.wr;
		ma_strand <= nx.strand;
		ma_index <= nx.index;
		ma_write_value <= nx.value;
		wb_latch_fault <= nx.fault;
		wb_fault_pc <= nx.pc;
		wb_fault_strand <= nx.fs;
		issue_stall <= nx.stall;
		nx = '0;
		@(negedge clk);
		check_outputs();
	endtask

	task automatic read_cr(input logic [1:0] strand, input logic [4:0] index);
		nx.rd = 1'b1;
		nx.strand = strand;
		nx.index = index;
		step();
	endtask

	task automatic write_cr(input logic [1:0] strand, input logic [4:0] index,
		input logic [31:0] value);
		nx.wr = 1'b1;
		nx.strand = strand;
		nx.index = index;
		nx.value = value;
		step();
	endtask

	initial
	begin
		#(TOTAL_CYCLES * 20 + 400);
		$display("Watchdog expired in %s, the run did not finish in time", test_name);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		logic [4:0] idx;
		logic [1:0] r;
		reset = 1'b1;
		{ma_read_en, ma_write_en, ma_strand, ma_index, ma_write_value} = '0;
		{wb_latch_fault, wb_fault_pc, wb_fault_strand, issue_stall} = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		read_cr(2'(random_bits(2)), cr_strand_enable);
		read_cr(0, cr_exception_handler);
		for (int s = 0; s < 4; s++)
			read_cr(2'(s), cr_fault_address);
		read_cr(0, 5'd9);
		repeat (4) step();
		check_value("issue after reset", 32'd1, 32'(issue_valid));
		check_value("issue strand after reset", 32'd0, 32'(issue_strand));

		test_name = "register read-back";
		repeat (RW_STEPS)
		begin
			r = 2'(random_bits(2));
			if (r == 0)
				write_cr(2'(random_bits(2)), cr_exception_handler, random_bits(32));
			else if (r == 1)
				write_cr(2'(random_bits(2)), cr_strand_enable, random_bits(32));
			else
				read_cr(2'(random_bits(2)),
					random_bits(1) ? cr_exception_handler : cr_strand_enable);
		end

		test_name = "strand id";
		for (int s = 0; s < 4; s++)
			read_cr(2'(s), cr_strand_id);
		repeat (RO_STEPS)
		begin
			idx = 5'(random_bits(5));
			// Keep to read-only and unused numbers
			if (idx == 1 || idx == 3 || idx == 29 || idx == 31)
				idx = cr_fault_address;
			write_cr(2'(random_bits(2)), idx, random_bits(32));
		end
		read_cr(0, cr_exception_handler);
		read_cr(1, cr_strand_enable);
		// Saved fault PCs must still be zero
		for (int s = 0; s < 4; s++)
			read_cr(2'(s), cr_fault_address);
		read_cr(2'(random_bits(2)), cr_strand_id);

		test_name = "fault capture";
		repeat (FAULT_STEPS)
		begin
			nx.fault = random_bits(1);
			nx.pc = random_bits(32);
			nx.fs = 2'(random_bits(2));
			if (random_bits(1))
				read_cr(2'(random_bits(2)), cr_fault_address);
			else
				step();
		end
		for (int s = 0; s < 4; s++)
			read_cr(2'(s), cr_fault_address);

		test_name = "halting";
		write_cr(0, cr_strand_enable, 32'hf);
		write_cr(2'(random_bits(2)), cr_halt_strand, random_bits(32));
		read_cr(2'(random_bits(2)), cr_strand_enable);
		write_cr(2'(random_bits(2)), cr_halt, random_bits(32));
		repeat (3) step();
		check_value("issue after halt", 32'd0, 32'(issue_valid));
		write_cr(0, cr_strand_enable, 32'h1);

		test_name = "scheduling";
		repeat (SCHED_STEPS)
		begin
			nx.stall = random_bits(1);
			if (random_bits(2) == 0)
				write_cr(2'(random_bits(2)), cr_strand_enable, random_bits(4));
			else
				step();
		end

		test_name = "drain";
		repeat (4) step();
		assert (reads.size() == 0)
		else
			report_failure("reads left unanswered at the end");

		$display("Checks done: %0d value errors, %0d other failures", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* common/control_pkg.sv */
/*
 * Types shared by the control register path.
 * Holds the register index map and the two views of a control register word.
 * Modules pull these in with a wildcard import in their header.
 */

`include "core_defines.svh"

package control_pkg;

	// Control register numbers as seen by the memory-access stage
	typedef enum logic [4:0]
	{
		cr_strand_id         = 5'd0,
		cr_exception_handler = 5'd1,
		cr_fault_address     = 5'd2,
		cr_strand_enable     = 5'd3,
		cr_halt_strand       = 5'd29,
		cr_halt              = 5'd31
	} cr_index_t;
	// Unlisted indices read as zero and drop writes

	// Core number fills whatever the strand number leaves
	typedef logic [`CR_WORD_WIDTH - `STRAND_INDEX_WIDTH - 1:0] core_number_t;

	// Layout of the read-only strand ID word
	typedef struct packed
	{
		core_number_t                    core;
		logic [`STRAND_INDEX_WIDTH - 1:0] strand;
	} strand_layout_t;

	// One control register word seen raw or as a strand ID
	typedef union packed
	{
		logic [`CR_WORD_WIDTH - 1:0] raw;
		strand_layout_t              id;
	} cr_word_t;

endpackage

/* common/core_defines.svh */
/*
 * Sizing macros for the core control block.
 * Include this wherever a strand count or a word width is needed.
 * The strand count must be a power of two that matches the index width.
 */

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Hardware strands in one core
`define STRANDS_PER_CORE 4

// Bits needed to number a strand
`define STRAND_INDEX_WIDTH 2

// Control register data width
`define CR_WORD_WIDTH 32

`endif

/* common/cr_bus_if.sv */
/*
 * One control register access between the access stage and the register file.
 * The stage drives the access; the register file answers with read data
 * in the same cycle. Read and write strobes are never high together.
 */

`include "core_defines.svh"

interface cr_bus_if
	import control_pkg::*;
();

	// Access fields
	logic [`STRAND_INDEX_WIDTH - 1:0] strand;
	cr_index_t                        index;
	logic                             read_en;
	logic                             write_en;
	logic [`CR_WORD_WIDTH - 1:0]      write_value;

	// Combinational answer for the current index and strand
	logic [`CR_WORD_WIDTH - 1:0]      read_value;

	// Access stage side
	modport stage (output strand, index, read_en, write_en, write_value,
		input read_value);

	// Register file side
	modport registers (input strand, index, read_en, write_en, write_value,
		output read_value);

endinterface

/* control/control_registers.sv */
/*
 * Control register file for one core.
 * Holds the strand enable mask, the exception handler address and a saved
 * fault PC per strand. Writes and fault latching take one edge, reads are
 * combinational from the bus index and the accessing strand.
 */

`include "core_defines.svh"

module control_registers
	import control_pkg::*;
#(
	parameter int unsigned core_id = 0
)
(
	input  logic                             clk,
	input  logic                             reset,

	// Fault report from writeback
	input  logic                             wb_latch_fault,
	input  logic [`CR_WORD_WIDTH - 1:0]      wb_fault_pc,
	input  logic [`STRAND_INDEX_WIDTH - 1:0] wb_fault_strand,

	// Access from the memory-access stage
	cr_bus_if.registers                      bus,

	// Live register values for the rest of the core
	output logic [`STRANDS_PER_CORE - 1:0]   strand_enable,
	output logic [`CR_WORD_WIDTH - 1:0]      exception_handler_address
);

	logic [`CR_WORD_WIDTH - 1:0] saved_fault_pc [`STRANDS_PER_CORE];
	cr_word_t                    read_word;

	// Read multiplexer
	always_comb
	begin
		read_word.raw = '0;
		case (bus.index)
			cr_strand_id:
			begin
				// Core number above the strand that asked
				read_word.id.core = core_number_t'(core_id);
				read_word.id.strand = bus.strand;
			end
			cr_exception_handler: read_word.raw = exception_handler_address;
			cr_fault_address:     read_word.raw = saved_fault_pc[bus.strand];
			// Mask sits in the low bits, rest stays zero
			cr_strand_enable:     read_word.raw[`STRANDS_PER_CORE - 1:0] = strand_enable;
			default:              read_word.raw = '0;
		endcase
	end

	assign bus.read_value = read_word.raw;

	// Register updates
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			// Only strand 0 runs out of reset
			strand_enable <= `STRANDS_PER_CORE'(1);
			exception_handler_address <= '0;
			for (int i = 0; i < `STRANDS_PER_CORE; i++)
				saved_fault_pc[i] <= '0;
		end
		else
		begin
			if (bus.write_en)
			begin
				case (bus.index)
					cr_exception_handler: exception_handler_address <= bus.write_value;
					cr_strand_enable: strand_enable <= bus.write_value[`STRANDS_PER_CORE - 1:0];
					// Writer stops itself
					cr_halt_strand:   strand_enable[bus.strand] <= 1'b0;
					cr_halt:          strand_enable <= '0;
					default:          ;
				endcase
			end

			// Writeback fault goes into the reporting strand's PC slot
			if (wb_latch_fault)
				saved_fault_pc[wb_fault_strand] <= wb_fault_pc;
		end
	end

endmodule

/* project.f */
+incdir+common
common/control_pkg.sv
common/cr_bus_if.sv
control/control_registers.sv
source/strand_select.sv
source/cr_access_stage.sv
source/core_control_top.sv
bench/core_control_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the run log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module core_control_tb \
	-o core_control_sim > build.log 2>&1 &&
./obj_dir/core_control_sim > sim.log 2>&1 &&
! grep -q "Something failed" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* source/core_control_top.sv */
/*
 * Control block of one processor core.
 * Connects the access stage, the control register file and the strand
 * selector. Pipeline, fault source and issue logic sit outside these ports.
 */

`include "core_defines.svh"

module core_control_top
	import control_pkg::*;
#(
	parameter int unsigned core_id = 0
)
(
	input  logic                             clk,
	input  logic                             reset,

	// Control register access from memory-access
	input  logic [`STRAND_INDEX_WIDTH - 1:0] ma_strand,
	input  logic [$bits(cr_index_t) - 1:0]   ma_index,
	input  logic                             ma_read_en,
	input  logic                             ma_write_en,
	input  logic [`CR_WORD_WIDTH - 1:0]      ma_write_value,

	// Fault report from writeback
	input  logic                             wb_latch_fault,
	input  logic [`CR_WORD_WIDTH - 1:0]      wb_fault_pc,
	input  logic [`STRAND_INDEX_WIDTH - 1:0] wb_fault_strand,

	// Back-pressure from issue
	input  logic                             issue_stall,

	// Read result to writeback
	output logic                             wb_read_valid,
	output logic [`CR_WORD_WIDTH - 1:0]      wb_read_value,

	// Issue choice
	output logic                             issue_valid,
	output logic [`STRAND_INDEX_WIDTH - 1:0] issue_strand,

	// Register state seen by the rest of the core
	output logic [`STRANDS_PER_CORE - 1:0]   strand_enable,
	output logic [`CR_WORD_WIDTH - 1:0]      exception_handler_address
);

	// Stage to register file
	cr_bus_if access_bus();

	cr_access_stage u_access
	(
		.clk            (clk),
		.reset          (reset),
		.ma_strand      (ma_strand),
		// Raw index bits onto the enumerated field
		.ma_index       (cr_index_t'(ma_index)),
		.ma_read_en     (ma_read_en),
		.ma_write_en    (ma_write_en),
		.ma_write_value (ma_write_value),
		.bus            (access_bus.stage),
		.wb_read_valid  (wb_read_valid),
		.wb_read_value  (wb_read_value)
	);

	control_registers #(.core_id(core_id)) u_regs
	(
		.clk                       (clk),
		.reset                     (reset),
		.wb_latch_fault            (wb_latch_fault),
		.wb_fault_pc               (wb_fault_pc),
		.wb_fault_strand           (wb_fault_strand),
		.bus                       (access_bus.registers),
		.strand_enable             (strand_enable),
		.exception_handler_address (exception_handler_address)
	);

	// Mask steers the selector and also leaves the block
	strand_select u_select
	(
		.clk           (clk),
		.reset         (reset),
		.strand_enable (strand_enable),
		.issue_stall   (issue_stall),
		.issue_valid   (issue_valid),
		.issue_strand  (issue_strand)
	);

endmodule

/* source/cr_access_stage.sv */
/*
 * Memory-access to writeback boundary for control register accesses.
 * Registers the incoming access onto the control register bus, then
 * registers the read answer for writeback. No back-pressure on this path.
 */

`include "core_defines.svh"

module cr_access_stage
	import control_pkg::*;
(
	input  logic                             clk,
	input  logic                             reset,

	// Access from the memory-access stage
	input  logic [`STRAND_INDEX_WIDTH - 1:0] ma_strand,
	input  cr_index_t                        ma_index,
	input  logic                             ma_read_en,
	input  logic                             ma_write_en,
	input  logic [`CR_WORD_WIDTH - 1:0]      ma_write_value,

	// Toward the register file
	cr_bus_if.stage                          bus,

	// Read result for writeback
	output logic                             wb_read_valid,
	output logic [`CR_WORD_WIDTH - 1:0]      wb_read_value
);

	// Access strobes and the writeback valid
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			bus.read_en <= 1'b0;
			bus.write_en <= 1'b0;
			wb_read_valid <= 1'b0;
		end
		else
		begin
			bus.read_en <= ma_read_en;
			bus.write_en <= ma_write_en;
			// One cycle pulse per staged read
			wb_read_valid <= bus.read_en;
		end
	end

	// Access payload and the read capture
	always_ff @(posedge clk)
	begin
		bus.strand <= ma_strand;
		bus.index <= ma_index;
		bus.write_value <= ma_write_value;

		// Capture the answer while the read is on the bus
		if (bus.read_en)
			wb_read_value <= bus.read_value;
	end

endmodule

/* source/strand_select.sv */
/*
 * Round-robin pick of the next strand to issue.
 * Searches from the strand after the last one issued for the first enabled
 * strand and registers it. Holds both outputs while issue_stall is high.
 */

`include "core_defines.svh"

module strand_select
(
	input  logic                             clk,
	input  logic                             reset,
	input  logic [`STRANDS_PER_CORE - 1:0]   strand_enable,
	input  logic                             issue_stall,
	output logic                             issue_valid,
	output logic [`STRAND_INDEX_WIDTH - 1:0] issue_strand
);

	logic                             next_valid;
	logic [`STRAND_INDEX_WIDTH - 1:0] next_strand;

	// Search the mask, starting one past the last issued strand
	always_comb
	begin
		int probe;

		next_valid = 1'b0;
		next_strand = issue_strand;
		for (int i = 1; i <= `STRANDS_PER_CORE; i++)
		begin
			probe = (int'(issue_strand) + i) % `STRANDS_PER_CORE;
			// First hit wins
			if (!next_valid && strand_enable[probe])
			begin
				next_valid = 1'b1;
				next_strand = `STRAND_INDEX_WIDTH'(probe);
			end
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			issue_valid <= 1'b0;
			// Start at the last strand so the first search lands on strand 0
			issue_strand <= `STRAND_INDEX_WIDTH'(`STRANDS_PER_CORE - 1);
		end
		else if (!issue_stall)
		begin
			issue_valid <= next_valid;
			// With nothing enabled the old strand stays as the search start
			issue_strand <= next_strand;
		end
	end

endmodule
